// File: pipe_pkg.sv
package pipe_pkg;

    localparam int word_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [word_w-1:0]     word_t;     // data or address word.
    typedef logic [reg_addr_w-1:0] reg_addr_t; // destination register number.

    // operation kinds that reach the back end.
    typedef enum logic [1:0] {
        OP_ADD   = 2'd0, // result is base plus offset.
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } op_kind_t;

endpackage

// File: lsu_pkg.sv
package lsu_pkg;

    localparam int lanes = 4; // byte lanes per word.

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_t;

    typedef logic [lanes-1:0] byte_en_t; // one bit per byte lane.

endpackage

// File: stage_if.sv
interface stage_if;

    logic                valid;
    logic                allow_in;
    pipe_pkg::word_t     pc;
    pipe_pkg::word_t     data;      // address or add result, final data after MEM.
    lsu_pkg::mem_size_t  size;
    logic                is_signed;
    logic                is_load;
    pipe_pkg::reg_addr_t dest;
    logic                we;

    modport sender (
        output valid,
        output pc,
        output data,
        output size,
        output is_signed,
        output is_load,
        output dest,
        output we,
        input  allow_in
    );

    modport receiver (
        input  valid,
        input  pc,
        input  data,
        input  size,
        input  is_signed,
        input  is_load,
        input  dest,
        input  we,
        output allow_in
    );

endinterface

// File: ex_stage.sv
module ex_stage #(
    parameter int ram_addr_w = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_allow,
    input  pipe_pkg::word_t         in_pc,
    input  pipe_pkg::op_kind_t      in_op,
    input  lsu_pkg::mem_size_t      in_size,
    input  logic                    in_signed,
    input  pipe_pkg::word_t         in_base,
    input  pipe_pkg::word_t         in_offset,
    input  pipe_pkg::word_t         in_store_data,
    input  pipe_pkg::reg_addr_t     in_dest,
    stage_if.sender                 out,
    output logic                    ram_en,
    output lsu_pkg::byte_en_t       ram_we,
    output logic [ram_addr_w-1:0]   ram_addr,
    output pipe_pkg::word_t         ram_wdata
);

    logic                ex_valid;
    logic                ex_go;
    pipe_pkg::word_t     pc_r;
    pipe_pkg::op_kind_t  op_r;
    lsu_pkg::mem_size_t  size_r;
    logic                signed_r;
    pipe_pkg::word_t     base_r;
    pipe_pkg::word_t     offset_r;
    pipe_pkg::word_t     store_data_r;
    pipe_pkg::reg_addr_t dest_r;
    pipe_pkg::word_t     addr;
    lsu_pkg::byte_en_t   byte_en;

    assign in_allow = ~ex_valid | out.allow_in; // always ready to go.
    assign ex_go    = ex_valid & out.allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (in_allow) begin
            ex_valid <= in_valid;
        end
        if (in_valid && in_allow) begin
            pc_r         <= in_pc;
            op_r         <= in_op;
            size_r       <= in_size;
            signed_r     <= in_signed;
            base_r       <= in_base;
            offset_r     <= in_offset;
            store_data_r <= in_store_data;
            dest_r       <= in_dest;
        end
    end

    assign addr = base_r + offset_r;

    // lanes written by a store; unaligned low bits are ignored.
    always_comb begin
        case (size_r)
            lsu_pkg::SZ_BYTE: byte_en = lsu_pkg::byte_en_t'(4'b0001 << addr[1:0]);
            lsu_pkg::SZ_HALF: byte_en = addr[1] ? 4'b1100 : 4'b0011;
            default:          byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        case (size_r)
            lsu_pkg::SZ_BYTE: ram_wdata = {4{store_data_r[7:0]}};
            lsu_pkg::SZ_HALF: ram_wdata = {2{store_data_r[15:0]}};
            default:          ram_wdata = store_data_r;
        endcase
    end

    assign ram_en   = ex_go & (op_r != pipe_pkg::OP_ADD);
    assign ram_we   = (ex_go && op_r == pipe_pkg::OP_STORE) ? byte_en : '0;
    assign ram_addr = addr[ram_addr_w+1:2]; // word index wraps with the RAM depth.

    assign out.valid     = ex_valid;
    assign out.pc        = pc_r;
    assign out.data      = addr;
    assign out.size      = size_r;
    assign out.is_signed = signed_r;
    assign out.is_load   = (op_r == pipe_pkg::OP_LOAD);
    assign out.dest      = dest_r;
    assign out.we        = (op_r != pipe_pkg::OP_STORE) && (dest_r != '0);

    // an item reaches the RAM only once.
    a_ram_issue: assert property (@(posedge clk) disable iff (reset)
        (ram_en && !(in_valid && in_allow)) |=> (!ram_en && ram_we == '0));

endmodule

// File: data_ram.sv
module data_ram #(
    parameter int ram_addr_w = 8
) (
    input  logic                  clk,
    input  logic                  en,
    input  lsu_pkg::byte_en_t     we,
    input  logic [ram_addr_w-1:0] addr,
    input  pipe_pkg::word_t       wdata,
    output pipe_pkg::word_t       rdata
);

    localparam int depth = 2 ** ram_addr_w;

    pipe_pkg::word_t mem [depth];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < lsu_pkg::lanes; i++) begin
                if (we[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            rdata <= mem[addr]; // old word on a write, loads never write.
        end
    end

endmodule

// File: mem_stage.sv
module mem_stage (
    input  logic            clk,
    input  logic            reset,
    stage_if.receiver       in,
    stage_if.sender         out,
    input  pipe_pkg::word_t ram_rdata
);

    logic                mem_valid;
    logic                first;      // item is in its first MEM cycle.
    pipe_pkg::word_t     rdata_hold;
    pipe_pkg::word_t     rdata_word;
    pipe_pkg::word_t     pc_r;
    pipe_pkg::word_t     result_r;
    lsu_pkg::mem_size_t  size_r;
    logic                signed_r;
    logic                is_load_r;
    pipe_pkg::reg_addr_t dest_r;
    logic                we_r;
    logic [7:0]          byte_sel;
    logic [15:0]         half_sel;
    pipe_pkg::word_t     load_data;

    assign in.allow_in = ~mem_valid | out.allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            first     <= 1'b0;
        end else begin
            if (in.allow_in) begin
                mem_valid <= in.valid;
            end
            first <= in.valid & in.allow_in;
        end
        if (first) begin
            rdata_hold <= ram_rdata; // the RAM output may move on while stalled.
        end
        if (in.valid && in.allow_in) begin
            pc_r      <= in.pc;
            result_r  <= in.data;
            size_r    <= in.size;
            signed_r  <= in.is_signed;
            is_load_r <= in.is_load;
            dest_r    <= in.dest;
            we_r      <= in.we;
        end
    end

    assign rdata_word = first ? ram_rdata : rdata_hold;

    always_comb begin
        case (result_r[1:0])
            2'b00:   byte_sel = rdata_word[7:0];
            2'b01:   byte_sel = rdata_word[15:8];
            2'b10:   byte_sel = rdata_word[23:16];
            default: byte_sel = rdata_word[31:24];
        endcase
    end

    assign half_sel = result_r[1] ? rdata_word[31:16] : rdata_word[15:0];

    always_comb begin
        case (size_r)
            lsu_pkg::SZ_BYTE: load_data = {{24{signed_r & byte_sel[7]}}, byte_sel};
            lsu_pkg::SZ_HALF: load_data = {{16{signed_r & half_sel[15]}}, half_sel};
            default:          load_data = rdata_word;
        endcase
    end

    assign out.valid     = mem_valid;
    assign out.pc        = pc_r;
    assign out.data      = is_load_r ? load_data : result_r;
    assign out.size      = size_r;
    assign out.is_signed = signed_r;
    assign out.is_load   = is_load_r;
    assign out.dest      = dest_r;
    assign out.we        = we_r;

    // a stalled load keeps the word that the RAM returned in its first cycle.
    a_rdata_held: assert property (@(posedge clk) disable iff (reset)
        (mem_valid && !out.allow_in) |=> $stable(rdata_word));

endmodule

// File: wb_stage.sv
module wb_stage (
    input  logic                clk,
    input  logic                reset,
    stage_if.receiver           in,
    output logic                out_valid,
    input  logic                out_ready,
    output pipe_pkg::word_t     out_pc,
    output logic                out_we,
    output pipe_pkg::reg_addr_t out_dest,
    output pipe_pkg::word_t     out_data
);

    logic                wb_valid;
    pipe_pkg::word_t     pc_r;
    logic                we_r;
    pipe_pkg::reg_addr_t dest_r;
    pipe_pkg::word_t     data_r;

    assign in.allow_in = ~wb_valid | out_ready; // out_ready acts as the next allow_in.

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (in.allow_in) begin
            wb_valid <= in.valid;
        end
        if (in.valid && in.allow_in) begin
            pc_r   <= in.pc;
            we_r   <= in.we;
            dest_r <= in.dest;
            data_r <= in.data;
        end
    end

    assign out_valid = wb_valid;
    assign out_pc    = pc_r;
    assign out_we    = we_r;
    assign out_dest  = dest_r;
    assign out_data  = data_r;

    // a result the acceptor has not taken stays put.
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable({out_pc, out_we, out_dest, out_data})));

endmodule

// File: lsu_top.sv
module lsu_top #(
    parameter int ram_addr_w = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_allow,
    input  pipe_pkg::word_t     in_pc,
    input  pipe_pkg::op_kind_t  in_op,
    input  lsu_pkg::mem_size_t  in_size,
    input  logic                in_signed,
    input  pipe_pkg::word_t     in_base,
    input  pipe_pkg::word_t     in_offset,
    input  pipe_pkg::word_t     in_store_data,
    input  pipe_pkg::reg_addr_t in_dest,
    output logic                out_valid,
    input  logic                out_ready,
    output pipe_pkg::word_t     out_pc,
    output logic                out_we,
    output pipe_pkg::reg_addr_t out_dest,
    output pipe_pkg::word_t     out_data
);

    logic                  ram_en;
    lsu_pkg::byte_en_t     ram_we;
    logic [ram_addr_w-1:0] ram_addr;
    pipe_pkg::word_t       ram_wdata;
    pipe_pkg::word_t       ram_rdata;

    stage_if ex_to_mem ();
    stage_if mem_to_wb ();

    ex_stage #(.ram_addr_w(ram_addr_w)) u_ex (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_allow      (in_allow),
        .in_pc         (in_pc),
        .in_op         (in_op),
        .in_size       (in_size),
        .in_signed     (in_signed),
        .in_base       (in_base),
        .in_offset     (in_offset),
        .in_store_data (in_store_data),
        .in_dest       (in_dest),
        .out           (ex_to_mem.sender),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata)
    );

    data_ram #(.ram_addr_w(ram_addr_w)) u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage u_mem (
        .clk       (clk),
        .reset     (reset),
        .in        (ex_to_mem.receiver),
        .out       (mem_to_wb.sender),
        .ram_rdata (ram_rdata)
    );

    wb_stage u_wb (
        .clk       (clk),
        .reset     (reset),
        .in        (mem_to_wb.receiver),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pc    (out_pc),
        .out_we    (out_we),
        .out_dest  (out_dest),
        .out_data  (out_data)
    );

endmodule

// File: tb_lsu.sv
module tb_lsu;

    localparam int ram_addr_w  = 4;
    localparam int num_ops     = 400;
    localparam int init_ops    = 2 ** ram_addr_w; // one word store per RAM word first.
    localparam int idle_cycles = 4;
    localparam int cycle_limit = 4 * num_ops + 50;

    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  dest;
        logic [31:0] data;
    } result_t;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_allow;
    pipe_pkg::word_t     in_pc;
    pipe_pkg::op_kind_t  in_op;
    lsu_pkg::mem_size_t  in_size;
    logic                in_signed;
    pipe_pkg::word_t     in_base;
    pipe_pkg::word_t     in_offset;
    pipe_pkg::word_t     in_store_data;
    pipe_pkg::reg_addr_t in_dest;
    logic                out_valid;
    logic                out_ready;
    pipe_pkg::word_t     out_pc;
    logic                out_we;
    pipe_pkg::reg_addr_t out_dest;
    pipe_pkg::word_t     out_data;

    logic [7:0]  mem_model [4 * init_ops]; // byte image of the data RAM.
    result_t     expect_q [$];
    result_t     held;
    logic        stalled;
    logic        waiting;  // offer still waiting for in_allow.
    logic [31:0] lfsr_state;
    int          issued;
    int          cycle;
    int          check_count;
    int          error_count;

    lsu_top #(.ram_addr_w(ram_addr_w)) UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic [31:0] model_word(input logic [ram_addr_w-1:0] w);
        return {mem_model[{w, 2'd3}], mem_model[{w, 2'd2}],
                mem_model[{w, 2'd1}], mem_model[{w, 2'd0}]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic build_op(input int idx);
        logic [31:0] r;
        in_pc         = 32'h1000 + 32'(idx * 4);
        in_store_data = rand_bits(32);
        r             = rand_bits(5);
        in_dest       = r[4:0];
        r             = rand_bits(1);
        in_signed     = r[0];
        if (idx < init_ops) begin
            in_op     = pipe_pkg::OP_STORE;
            in_size   = lsu_pkg::SZ_WORD;
            in_base   = 32'(idx * 4);
            in_offset = '0;
        end else begin
            in_base   = rand_bits(32);
            r         = rand_bits(8);
            in_offset = {{24{r[7]}}, r[7:0]}; // small signed offset.
            r         = rand_bits(2);
            case (r[1:0])
                2'd0:    in_op = pipe_pkg::OP_ADD;
                2'd3:    in_op = pipe_pkg::OP_STORE;
                default: in_op = pipe_pkg::OP_LOAD;
            endcase
            r = rand_bits(2);
            case (r[1:0])
                2'd0:    in_size = lsu_pkg::SZ_BYTE;
                2'd1:    in_size = lsu_pkg::SZ_HALF;
                default: in_size = lsu_pkg::SZ_WORD;
            endcase
        end
    endtask

    task automatic model_accept();
        result_t               e;
        logic [31:0]           addr;
        logic [ram_addr_w-1:0] w;
        logic [31:0]           word;
        logic [7:0]            b;
        logic [15:0]           h;
        addr   = in_base + in_offset;
        w      = addr[ram_addr_w+1:2];
        word   = model_word(w);
        b      = word[8*addr[1:0] +: 8];
        h      = addr[1] ? word[31:16] : word[15:0];
        e.pc   = in_pc;
        e.dest = in_dest;
        e.we   = (in_op != pipe_pkg::OP_STORE) && (in_dest != 5'd0);
        e.data = addr;
        if (in_op == pipe_pkg::OP_LOAD) begin
            case (in_size)
                lsu_pkg::SZ_BYTE: e.data = in_signed ? 32'($signed(b)) : 32'(b);
                lsu_pkg::SZ_HALF: e.data = in_signed ? 32'($signed(h)) : 32'(h);
                default:          e.data = word;
            endcase
        end else if (in_op == pipe_pkg::OP_STORE) begin
            case (in_size)
                lsu_pkg::SZ_BYTE: mem_model[{w, addr[1:0]}] = in_store_data[7:0];
                lsu_pkg::SZ_HALF: begin
                    mem_model[{w, addr[1], 1'b0}] = in_store_data[7:0];
                    mem_model[{w, addr[1], 1'b1}] = in_store_data[15:8];
                end
                default: begin
                    for (int i = 0; i < 4; i++) begin
                        mem_model[{w, 2'(i)}] = in_store_data[8*i +: 8];
                    end
                end
            endcase
        end
        expect_q.push_back(e);
        issued++;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        if (!waiting) begin
            r = rand_bits(2);
            if (issued < num_ops && cycle >= idle_cycles && r[1:0] != 2'd0) begin
                build_op(issued);
                in_valid = 1'b1;
            end else begin
                in_valid = 1'b0;
            end
        end
        r         = rand_bits(2);
        out_ready = (r[1:0] != 2'd0); // mostly ready.
    endtask

    task automatic sample_outputs();
        result_t e;
        if (issued == 0) begin
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("in_allow", 32'(in_allow), 32'd1);
        end
        if (stalled) begin
            check_value("out_valid (stalled)", 32'(out_valid), 32'd1);
            check_value("out_pc (stalled)", out_pc, held.pc);
            check_value("out_we (stalled)", 32'(out_we), 32'(held.we));
            check_value("out_dest (stalled)", 32'(out_dest), 32'(held.dest));
            check_value("out_data (stalled)", out_data, held.data);
        end
        stalled = out_valid && !out_ready;
        held    = {out_pc, out_we, out_dest, out_data};
        waiting = in_valid && !in_allow;
        if (in_valid && in_allow) begin
            model_accept();
        end
        if (out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
                error_count++;
                $display("result for pc %h came out with no operation outstanding", out_pc);
            end else begin
                e = expect_q.pop_front();
                check_value("out_pc", out_pc, e.pc);
                check_value("out_we", 32'(out_we), 32'(e.we));
                check_value("out_dest", 32'(out_dest), 32'(e.dest));
                check_value("out_data", out_data, e.data);
            end
        end
    endtask

    initial begin
        lfsr_state    = 32'h64012fb3;
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_op         = pipe_pkg::OP_ADD;
        in_size       = lsu_pkg::SZ_WORD;
        in_signed     = 1'b0;
        in_base       = '0;
        in_offset     = '0;
        in_store_data = '0;
        in_dest       = '0;
        out_ready     = 1'b0;
        issued        = 0;
        cycle         = 0;
        check_count   = 0;
        error_count   = 0;
        stalled       = 1'b0;
        waiting       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (cycle < cycle_limit && !(issued == num_ops && expect_q.size() == 0)) begin
            drive_inputs();
            #2; // mid low phase, everything settled.
            sample_outputs();
            cycle++;
            @(negedge clk);
        end
        if (!(issued == num_ops && expect_q.size() == 0)) begin
            error_count++;
            $display("run stopped at the cycle limit with %0d of %0d operations accepted",
                     issued, num_ops);
        end
        $display("checks %0d, errors %0d, operations %0d, cycles %0d",
                 check_count, error_count, issued, cycle);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
pipe_pkg.sv
lsu_pkg.sv
stage_if.sv
ex_stage.sv
data_ram.sv
mem_stage.sv
wb_stage.sv
lsu_top.sv
tb_lsu.sv

// File: run.sh
#!/bin/sh
# build and run; the log decides pass or fail.
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lsu -f sim.f \
    && ./obj_dir/Vtb_lsu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
